//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= cekirdek_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- aritmetik_mantik_birimi.sv
// combinational ALU: add, subtract, logic, compares, shifts and LUI.
`default_nettype none

module aritmetik_mantik_birimi (
    input  tanimlamalar_pkg::islem_t islem_i,
    output tanimlamalar_pkg::sonuc_t sonuc_o
);

    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  kaydirma;
    logic [31:0] deger;
    logic        bu_birim;

    assign a        = islem_i.deger1;
    assign b        = islem_i.deger2;
    assign kaydirma = islem_i.deger2[4:0];

    always_comb begin
        bu_birim = 1'b1;
        deger    = '0;
        case (islem_i.mikroislem)
            tanimlamalar_pkg::ISLEM_ADD:  deger = a + b;
            tanimlamalar_pkg::ISLEM_SUB:  deger = a - b;
            tanimlamalar_pkg::ISLEM_AND:  deger = a & b;
            tanimlamalar_pkg::ISLEM_OR:   deger = a | b;
            tanimlamalar_pkg::ISLEM_XOR:  deger = a ^ b;
            tanimlamalar_pkg::ISLEM_SLT:  deger = {31'd0, $signed(a) < $signed(b)};
            tanimlamalar_pkg::ISLEM_SLTU: deger = {31'd0, a < b};
            tanimlamalar_pkg::ISLEM_SLL:  deger = a << kaydirma;
            tanimlamalar_pkg::ISLEM_SRL:  deger = a >> kaydirma;
            tanimlamalar_pkg::ISLEM_SRA:  deger = $signed(a) >>> kaydirma;
            // upper immediate is already formed in decode.
            tanimlamalar_pkg::ISLEM_LUI:  deger = b;
            default: begin
                bu_birim = 1'b0;
            end
        endcase
    end

    assign sonuc_o.gecerli = islem_i.gecerli && bu_birim;
    assign sonuc_o.deger   = deger;

endmodule

`default_nettype wire

//--- carpma_birimi.sv
// combinational multiplier for MUL, MULH and MULHU.
`default_nettype none

module carpma_birimi (
    input  tanimlamalar_pkg::islem_t islem_i,
    output tanimlamalar_pkg::sonuc_t sonuc_o
);

    logic               isaretli;
    logic [32:0]        a_genis;
    logic [32:0]        b_genis;
    logic signed [65:0] carpim;
    logic [31:0]        deger;
    logic               bu_birim;

    // one 33x33 signed multiply covers both signed and unsigned operands.
    assign isaretli = (islem_i.mikroislem != tanimlamalar_pkg::ISLEM_MULHU);
    assign a_genis  = {isaretli & islem_i.deger1[31], islem_i.deger1};
    assign b_genis  = {isaretli & islem_i.deger2[31], islem_i.deger2};
    assign carpim   = $signed(a_genis) * $signed(b_genis);

    always_comb begin
        bu_birim = 1'b1;
        deger    = carpim[63:32];
        case (islem_i.mikroislem)
            tanimlamalar_pkg::ISLEM_MUL:   deger = carpim[31:0];
            tanimlamalar_pkg::ISLEM_MULH:  deger = carpim[63:32];
            tanimlamalar_pkg::ISLEM_MULHU: deger = carpim[63:32];
            default: begin
                bu_birim = 1'b0;
            end
        endcase
    end

    assign sonuc_o.gecerli = islem_i.gecerli && bu_birim;
    assign sonuc_o.deger   = deger;

endmodule

`default_nettype wire

//--- cekirdek.sv
// core top level: fetch, decode, ALU, multiplier and writeback.
`default_nettype none

module cekirdek #(
    parameter logic [31:0] BASLANGIC_PS = 32'h0000_0000
) (
    input  logic                     clk_i,
    input  logic                     rst_i,

    input  logic                     l1b_bekle_i,
    input  logic [31:0]              l1b_deger_i,
    output logic                     l1b_chip_select_n_o,
    output logic [31:0]              l1b_adres_o,

    output tanimlamalar_pkg::yazma_t gy_yaz_o
);

    logic [29:0]               l1b_adr_w;
    tanimlamalar_pkg::buyruk_t cyo_buyruk_w;
    tanimlamalar_pkg::islem_t  yrt_islem_w;
    tanimlamalar_pkg::sonuc_t  ibr_sonuc_w;
    tanimlamalar_pkg::sonuc_t  crp_sonuc_w;
    tanimlamalar_pkg::yazma_t  gy_yaz_w;

    getir #(
        .BASLANGIC_PS(BASLANGIC_PS)
    ) getir_dut (
        .clk_i              (clk_i              ),
        .rst_i              (rst_i              ),
        .l1b_bekle_i        (l1b_bekle_i        ),
        .l1b_deger_i        (l1b_deger_i        ),
        .l1b_chip_select_n_o(l1b_chip_select_n_o),
        .l1b_adr_o          (l1b_adr_w          ),
        .cyo_buyruk_o       (cyo_buyruk_w       )
    );

    coz_yazmacoku coz_yazmacoku_dut (
        .clk_i       (clk_i       ),
        .rst_i       (rst_i       ),
        .gtr_buyruk_i(cyo_buyruk_w),
        .gy_yaz_i    (gy_yaz_w    ),
        .yrt_islem_o (yrt_islem_w )
    );

    // both units see every operation and flag only their own.
    aritmetik_mantik_birimi aritmetik_mantik_birimi_dut (
        .islem_i(yrt_islem_w),
        .sonuc_o(ibr_sonuc_w)
    );

    carpma_birimi carpma_birimi_dut (
        .islem_i(yrt_islem_w),
        .sonuc_o(crp_sonuc_w)
    );

    geri_yaz geri_yaz_dut (
        .clk_i      (clk_i               ),
        .rst_i      (rst_i               ),
        .ibr_sonuc_i(ibr_sonuc_w         ),
        .crp_sonuc_i(crp_sonuc_w         ),
        .rd_adres_i (yrt_islem_w.rd_adres),
        .gy_yaz_o   (gy_yaz_w            )
    );

    assign l1b_adres_o = {l1b_adr_w, 2'b00};
    assign gy_yaz_o    = gy_yaz_w;

endmodule

`default_nettype wire

//--- cekirdek_denetleyici.sv
// testbench checker: reference model, register model, writeback comparison and reporting.
`default_nettype none

module cekirdek_denetleyici #(
    parameter logic [31:0] BASLANGIC_PS = 32'h0000_0000,
    parameter int          KESIM_BOY    = 40,
    parameter int          KESIM_SAYISI = 5
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic [31:0]              program_i [0:255],
    input  tanimlamalar_pkg::yazma_t gy_yaz_i,
    input  logic [31:0]              adres_i,
    input  logic                     cs_n_i,
    input  logic                     bekle_i,
    input  logic                     son_i,
    output int                       hata_o,
    output logic                     bitti_o
);

    localparam int TEST_BOY = KESIM_BOY * KESIM_SAYISI;

    logic [31:0] mimari [0:31];
    logic [31:0] beklenen_adres;
    logic        ilk_cikis;
    logic        ilk_adres;
    int          sira;
    int          hata            = 0;
    int          yazma_sayisi    = 0;
    int          beklenen_sayisi = 0;
    int          reset_kenar     = 0;
    int          reset_hata      = 0;
    int          adres_hata      = 0;
    int          kesim_hata  [0:KESIM_SAYISI-1] = '{default: 0};
    int          kesim_yazma [0:KESIM_SAYISI-1] = '{default: 0};

    assign hata_o = hata;

    function automatic string kesim_adi(input int k);
        string ad;
        case (k)
            0:       ad = "alu";
            1:       ad = "multiply";
            2:       ad = "dependency";
            3:       ad = "x0_invalid";
            default: ad = "mixed";
        endcase
        return ad;
    endfunction

    function automatic logic [31:0] alu_hesap(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] x, input logic [31:0] y);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? x - y : x + y;
            3'd1: r = x << y[4:0];
            3'd2: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3: r = (x < y) ? 32'd1 : 32'd0;
            3'd4: r = x ^ y;
            3'd5: begin
                if (alt) begin
                    r = $signed(x) >>> y[4:0];
                end else begin
                    r = x >> y[4:0];
                end
            end
            3'd6: r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    // bit 32 says whether the instruction writes a register, bits 31:0 hold the value.
    function automatic logic [32:0] beklenen_sonuc(input logic [31:0] b);
        logic [31:0] a;
        logic [31:0] c;
        logic [31:0] imm;
        logic [63:0] carpim;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        yazar;
        logic [31:0] d;
        a      = mimari[b[19:15]];
        c      = mimari[b[24:20]];
        f3     = b[14:12];
        f7     = b[31:25];
        imm    = {{20{b[31]}}, b[31:20]};
        yazar  = 1'b1;
        d      = '0;
        carpim = '0;
        if (b[6:0] == tanimlamalar_pkg::OPC_LUI) begin
            d = {b[31:12], 12'h000};
        end else if (b[6:0] == tanimlamalar_pkg::OPC_OP_IMM) begin
            if (f3 == 3'd1 && f7 != 7'd0) begin
                yazar = 1'b0;
            end else if (f3 == 3'd5 && f7 != 7'd0 && f7 != 7'b0100000) begin
                yazar = 1'b0;
            end else begin
                d = alu_hesap(f3, f7[5] && f3 == 3'd5, a, imm);
            end
        end else if (b[6:0] == tanimlamalar_pkg::OPC_OP) begin
            if (f7 == 7'd1) begin
                case (f3)
                    3'd0: carpim = {{32{a[31]}}, a} * {{32{c[31]}}, c};
                    3'd1: carpim = {{32{a[31]}}, a} * {{32{c[31]}}, c};
                    3'd3: carpim = {32'd0, a} * {32'd0, c};
                    default: yazar = 1'b0;
                endcase
                d = (f3 == 3'd0) ? carpim[31:0] : carpim[63:32];
            end else if (f7 == 7'd0 || (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5))) begin
                d = alu_hesap(f3, f7[5], a, c);
            end else begin
                yazar = 1'b0;
            end
        end else begin
            yazar = 1'b0;
        end
        if (b[11:7] == 5'd0) begin
            yazar = 1'b0;
        end
        return {yazar, d};
    endfunction

    task automatic kesim_kapat(input int k);
        $display("test %s %s, %0d writebacks", kesim_adi(k),
                 (kesim_hata[k] == 0) ? "passed" : "failed", kesim_yazma[k]);
    endtask

    task automatic ilerle();
        sira++;
        if (sira % KESIM_BOY == 0) begin
            kesim_kapat(sira / KESIM_BOY - 1);
        end
    endtask

    task automatic yazmayanlari_atla();
        logic [32:0] r;
        while (sira < TEST_BOY) begin
            r = beklenen_sonuc(program_i[sira]);
            if (r[32]) begin
                break;
            end
            ilerle();
        end
    endtask

    task automatic yazma_denetle();
        logic [32:0] beklenen;
        logic [4:0]  rd;
        int          k;
        yazmayanlari_atla();
        yazma_sayisi++;
        if (sira >= TEST_BOY) begin
            $display("unexpected writeback to x%0d after the end of the program",
                     gy_yaz_i.adres);
            hata++;
        end else begin
            beklenen = beklenen_sonuc(program_i[sira]);
            rd       = program_i[sira][11:7];
            k        = sira / KESIM_BOY;
            beklenen_sayisi++;
            kesim_yazma[k]++;
            if (gy_yaz_i.adres !== rd || gy_yaz_i.deger !== beklenen[31:0]) begin
                $display("FAIL %s: instruction %0d expected x%0d=%h actual x%0d=%h",
                         kesim_adi(k), sira, rd, beklenen[31:0],
                         gy_yaz_i.adres, gy_yaz_i.deger);
                kesim_hata[k]++;
                hata++;
            end
            // the model follows the expected value so one error does not cascade.
            mimari[rd] = beklenen[31:0];
            ilerle();
        end
    endtask

    task automatic bitir();
        logic [32:0] r;
        while (sira < TEST_BOY) begin
            r = beklenen_sonuc(program_i[sira]);
            if (r[32]) begin
                $display("missing writeback for instruction %0d to x%0d",
                         sira, program_i[sira][11:7]);
                kesim_hata[sira / KESIM_BOY]++;
                beklenen_sayisi++;
                hata++;
            end
            ilerle();
        end
        $display("test fetch_order %s", (adres_hata == 0) ? "passed" : "failed");
        $display("writebacks %0d of %0d expected, errors %0d",
                 yazma_sayisi, beklenen_sayisi, hata);
    endtask

    always @(posedge clk_i) begin
        if (rst_i) begin
            if (reset_kenar > 0 && (cs_n_i !== 1'b1 || gy_yaz_i.gecerli !== 1'b0)) begin
                $display("reset: chip select active or writeback valid during reset");
                reset_hata++;
                hata++;
            end
            reset_kenar++;
            for (int i = 0; i < 32; i++) begin
                mimari[i] = '0;
            end
            sira           = 0;
            beklenen_adres = BASLANGIC_PS;
            ilk_cikis      = 1'b1;
            ilk_adres      = 1'b1;
            bitti_o       <= 1'b0;
        end else begin
            if (ilk_cikis) begin
                if (cs_n_i !== 1'b1 || gy_yaz_i.gecerli !== 1'b0) begin
                    $display("reset: chip select or writeback active in the first cycle out");
                    reset_hata++;
                    hata++;
                end
                ilk_cikis = 1'b0;
            end else if (cs_n_i !== 1'b0) begin
                $display("fetch_order: chip select inactive while out of reset");
                adres_hata++;
                hata++;
            end
            if (cs_n_i === 1'b0 && bekle_i === 1'b0) begin
                if (adres_i !== beklenen_adres) begin
                    $display("FAIL %s: expected address %h actual %h",
                             ilk_adres ? "reset" : "fetch_order", beklenen_adres, adres_i);
                    if (ilk_adres) begin
                        reset_hata++;
                    end else begin
                        adres_hata++;
                    end
                    hata++;
                end
                beklenen_adres = beklenen_adres + 32'd4;
                if (ilk_adres) begin
                    $display("test reset %s", (reset_hata == 0) ? "passed" : "failed");
                    ilk_adres = 1'b0;
                end
            end
            if (gy_yaz_i.gecerli === 1'b1) begin
                yazma_denetle();
            end
            if (son_i && !bitti_o) begin
                bitir();
                bitti_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- cekirdek_tb.sv
// testbench top: clock, reset, program memory, random program, wait strobe and timeout.
`default_nettype none

module cekirdek_tb;

    localparam logic [31:0] BASLANGIC_PS = 32'h0000_0000;
    localparam int          KESIM_BOY    = 40;
    localparam int          KESIM_SAYISI = 5;
    localparam int          TEST_BOY     = KESIM_BOY * KESIM_SAYISI;
    localparam int          BITIS        = TEST_BOY + 20;
    localparam int          ZAMAN_SINIRI = 256 * 2 + 100;
    localparam logic [31:0] NOP          = 32'h0000_0013;

    logic                     clk;
    logic                     rst;
    logic                     l1b_bekle = 1'b0;
    logic [31:0]              l1b_deger;
    logic                     l1b_cs_n;
    logic [31:0]              l1b_adres;
    tanimlamalar_pkg::yazma_t gy_yaz;
    logic                     son = 1'b0;
    logic                     bitti;
    int                       hata;
    int                       dongu = 0;
    logic [31:0]              program_bellek [0:255];
    logic                     yazildi [0:31];
    logic [7:0]               bellek_indis;

    // the memory answers in the same cycle as the address.
    assign bellek_indis = 8'((l1b_adres - BASLANGIC_PS) >> 2);
    assign l1b_deger    = program_bellek[bellek_indis];

    cekirdek #(
        .BASLANGIC_PS(BASLANGIC_PS)
    ) dut0 (
        .clk_i              (clk      ),
        .rst_i              (rst      ),
        .l1b_bekle_i        (l1b_bekle),
        .l1b_deger_i        (l1b_deger),
        .l1b_chip_select_n_o(l1b_cs_n ),
        .l1b_adres_o        (l1b_adres),
        .gy_yaz_o           (gy_yaz   )
    );

    cekirdek_denetleyici #(
        .BASLANGIC_PS(BASLANGIC_PS),
        .KESIM_BOY   (KESIM_BOY   ),
        .KESIM_SAYISI(KESIM_SAYISI)
    ) denetci0 (
        .clk_i    (clk           ),
        .rst_i    (rst           ),
        .program_i(program_bellek),
        .gy_yaz_i (gy_yaz        ),
        .adres_i  (l1b_adres     ),
        .cs_n_i   (l1b_cs_n      ),
        .bekle_i  (l1b_bekle     ),
        .son_i    (son           ),
        .hata_o   (hata          ),
        .bitti_o  (bitti         )
    );

    function automatic logic [31:0] r_tipi(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, tanimlamalar_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_tipi(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, tanimlamalar_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] u_tipi(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, tanimlamalar_pkg::OPC_LUI};
    endfunction

    // registers never written yet are replaced by x0 so no read sees an unknown value.
    function automatic logic [4:0] kaynak(input int ust);
        int r;
        r = 1 + int'($urandom % ust);
        return yazildi[r] ? 5'(r) : 5'd0;
    endfunction

    task automatic alu_uret(input int ust, input logic [4:0] rd, output logic [31:0] b);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          tur;
        tur = int'($urandom % 3);
        f3  = 3'($urandom);
        f7  = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 0)) ? 7'b0100000 : 7'd0;
        imm = 12'($urandom);
        if (tur == 0) begin
            b = r_tipi(f7, kaynak(ust), kaynak(ust), f3, rd);
        end else if (tur == 1) begin
            if (f3 == 3'd1) begin
                imm[11:5] = 7'd0;
            end else if (f3 == 3'd5) begin
                imm[11:5] = f7;
            end
            b = i_tipi(imm, kaynak(ust), f3, rd);
        end else begin
            b = u_tipi(20'($urandom), rd);
        end
        if (rd != 5'd0) begin
            yazildi[rd] = 1'b1;
        end
    endtask

    task automatic carpma_uret(input int ust, input logic [4:0] rd, output logic [31:0] b);
        int secim;
        secim = int'($urandom % 3);
        b = r_tipi(7'd1, kaynak(ust), kaynak(ust), (secim == 2) ? 3'd3 : 3'(secim), rd);
        yazildi[rd] = 1'b1;
    endtask

    task automatic gecersiz_uret(input logic [4:0] rd, output logic [31:0] b);
        case ($urandom % 4)
            0: alu_uret(31, 5'd0, b);
            1: b = {25'($urandom), 7'b0000011};
            2: begin
                // reads x0 into a real register.
                b = i_tipi(12'($urandom), 5'd0, 3'd0, rd);
                yazildi[rd] = 1'b1;
            end
            default: b = r_tipi(7'b0000010, kaynak(31), kaynak(31), 3'($urandom), rd);
        endcase
    endtask

    task automatic program_olustur();
        logic [31:0] b;
        logic [4:0]  rd;
        for (int i = 0; i < 256; i++) begin
            program_bellek[i] = NOP;
        end
        for (int i = 0; i < 32; i++) begin
            yazildi[i] = 1'b0;
        end
        for (int i = 0; i < TEST_BOY; i++) begin
            rd = 5'(1 + $urandom % 31);
            case (i / KESIM_BOY)
                0: alu_uret(31, rd, b);
                1: begin
                    // a fresh upper value every third slot gives negative operands.
                    if (i % 3 == 0) begin
                        b = u_tipi(20'($urandom), rd);
                        yazildi[rd] = 1'b1;
                    end else begin
                        carpma_uret(31, rd, b);
                    end
                end
                2: begin
                    rd = 5'(1 + $urandom % 3);
                    if ($urandom % 4 == 0) begin
                        carpma_uret(3, rd, b);
                    end else begin
                        alu_uret(3, rd, b);
                    end
                end
                3: gecersiz_uret(rd, b);
                default: begin
                    if ($urandom % 3 == 0) begin
                        carpma_uret(31, rd, b);
                    end else begin
                        alu_uret(31, rd, b);
                    end
                end
            endcase
            program_bellek[i] = b;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // no wait states while segment 1 is fetched.
    always @(posedge clk) begin
        if (rst) begin
            l1b_bekle <= 1'b0;
        end else begin
            l1b_bekle <= (l1b_adres >= BASLANGIC_PS + 32'(KESIM_BOY * 4)) &&
                         ($urandom % 4 == 0);
        end
    end

    always @(posedge clk) begin
        dongu <= dongu + 1;
        if (dongu >= ZAMAN_SINIRI) begin
            $display("timeout: the run stalled, program end not reached in %0d cycles", dongu);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        void'($urandom(89917));
        program_olustur();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        while (l1b_adres < BASLANGIC_PS + 32'(BITIS * 4)) begin
            @(posedge clk);
        end
        son <= 1'b1;
        @(posedge clk);
        son <= 1'b0;
        while (!bitti) begin
            @(posedge clk);
        end
        if (hata == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- coz_yazmacoku.sv
// decode and register read: field decode, register file, write-through and forwarding.
`default_nettype none

module coz_yazmacoku (
    input  logic                      clk_i,
    input  logic                      rst_i,

    input  tanimlamalar_pkg::buyruk_t gtr_buyruk_i,
    input  tanimlamalar_pkg::yazma_t  gy_yaz_i,
    output tanimlamalar_pkg::islem_t  yrt_islem_o
);

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;

    tanimlamalar_pkg::mikroislem_e mikroislem;
    logic        rs2_kullan;
    logic [31:0] islenen2;

    logic [31:0] yazmaclar [0:31];

    logic        gecerli_r;
    tanimlamalar_pkg::mikroislem_e mikroislem_r;
    logic [4:0]  rd_r;
    logic [4:0]  rs1_r;
    logic [4:0]  rs2_r;
    logic        rs2_kullan_r;
    logic [31:0] deger1_r;
    logic [31:0] deger2_r;

    // x0 reads as zero, a same-cycle write is seen at once.
    function automatic logic [31:0] yazmac_oku(input logic [4:0] adres);
        logic [31:0] sonuc;
        if (adres == 5'd0) begin
            sonuc = '0;
        end else if (gy_yaz_i.gecerli && (gy_yaz_i.adres == adres)) begin
            sonuc = gy_yaz_i.deger;
        end else begin
            sonuc = yazmaclar[adres];
        end
        return sonuc;
    endfunction

    assign opcode = gtr_buyruk_i.buyruk[6:0];
    assign rd     = gtr_buyruk_i.buyruk[11:7];
    assign funct3 = gtr_buyruk_i.buyruk[14:12];
    assign rs1    = gtr_buyruk_i.buyruk[19:15];
    assign rs2    = gtr_buyruk_i.buyruk[24:20];
    assign funct7 = gtr_buyruk_i.buyruk[31:25];
    assign imm_i  = {{20{gtr_buyruk_i.buyruk[31]}}, gtr_buyruk_i.buyruk[31:20]};
    assign imm_u  = {gtr_buyruk_i.buyruk[31:12], 12'd0};

    always_comb begin
        mikroislem = tanimlamalar_pkg::ISLEM_NOP;
        rs2_kullan = 1'b0;
        islenen2   = imm_i;
        case (opcode)
            tanimlamalar_pkg::OPC_OP: begin
                rs2_kullan = 1'b1;
                islenen2   = yazmac_oku(rs2);
                case ({funct7, funct3})
                    10'b0000000_000: mikroislem = tanimlamalar_pkg::ISLEM_ADD;
                    10'b0100000_000: mikroislem = tanimlamalar_pkg::ISLEM_SUB;
                    10'b0000000_001: mikroislem = tanimlamalar_pkg::ISLEM_SLL;
                    10'b0000000_010: mikroislem = tanimlamalar_pkg::ISLEM_SLT;
                    10'b0000000_011: mikroislem = tanimlamalar_pkg::ISLEM_SLTU;
                    10'b0000000_100: mikroislem = tanimlamalar_pkg::ISLEM_XOR;
                    10'b0000000_101: mikroislem = tanimlamalar_pkg::ISLEM_SRL;
                    10'b0100000_101: mikroislem = tanimlamalar_pkg::ISLEM_SRA;
                    10'b0000000_110: mikroislem = tanimlamalar_pkg::ISLEM_OR;
                    10'b0000000_111: mikroislem = tanimlamalar_pkg::ISLEM_AND;
                    10'b0000001_000: mikroislem = tanimlamalar_pkg::ISLEM_MUL;
                    10'b0000001_001: mikroislem = tanimlamalar_pkg::ISLEM_MULH;
                    10'b0000001_011: mikroislem = tanimlamalar_pkg::ISLEM_MULHU;
                    default:         mikroislem = tanimlamalar_pkg::ISLEM_NOP;
                endcase
            end
            tanimlamalar_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b000: mikroislem = tanimlamalar_pkg::ISLEM_ADD;
                    3'b010: mikroislem = tanimlamalar_pkg::ISLEM_SLT;
                    3'b011: mikroislem = tanimlamalar_pkg::ISLEM_SLTU;
                    3'b100: mikroislem = tanimlamalar_pkg::ISLEM_XOR;
                    3'b110: mikroislem = tanimlamalar_pkg::ISLEM_OR;
                    3'b111: mikroislem = tanimlamalar_pkg::ISLEM_AND;
                    3'b001: begin
                        if (funct7 == 7'b0000000) begin
                            mikroislem = tanimlamalar_pkg::ISLEM_SLL;
                        end
                    end
                    default: begin
                        // shift right, funct7 picks logical or arithmetic.
                        if (funct7 == 7'b0000000) begin
                            mikroislem = tanimlamalar_pkg::ISLEM_SRL;
                        end else if (funct7 == 7'b0100000) begin
                            mikroislem = tanimlamalar_pkg::ISLEM_SRA;
                        end
                    end
                endcase
            end
            tanimlamalar_pkg::OPC_LUI: begin
                mikroislem = tanimlamalar_pkg::ISLEM_LUI;
                islenen2   = imm_u;
            end
            default: begin
                mikroislem = tanimlamalar_pkg::ISLEM_NOP;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (gy_yaz_i.gecerli) begin
            yazmaclar[gy_yaz_i.adres] <= gy_yaz_i.deger;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gecerli_r <= 1'b0;
        end else begin
            gecerli_r <= gtr_buyruk_i.gecerli;
        end
    end

    always_ff @(posedge clk_i) begin
        mikroislem_r <= mikroislem;
        rd_r         <= rd;
        rs1_r        <= rs1;
        rs2_r        <= rs2;
        rs2_kullan_r <= rs2_kullan;
        deger1_r     <= yazmac_oku(rs1);
        deger2_r     <= islenen2;
    end

    // the previous instruction is in writeback now, take its result.
    assign yrt_islem_o.gecerli    = gecerli_r;
    assign yrt_islem_o.mikroislem = mikroislem_r;
    assign yrt_islem_o.rd_adres   = rd_r;
    assign yrt_islem_o.deger1     = (gy_yaz_i.gecerli && (gy_yaz_i.adres == rs1_r)) ?
                                    gy_yaz_i.deger : deger1_r;
    assign yrt_islem_o.deger2     = (gy_yaz_i.gecerli && rs2_kullan_r &&
                                     (gy_yaz_i.adres == rs2_r)) ? gy_yaz_i.deger : deger2_r;

endmodule

`default_nettype wire

//--- geri_yaz.sv
// writeback register: picks the valid execute result and drops writes to x0.
`default_nettype none

module geri_yaz (
    input  logic                     clk_i,
    input  logic                     rst_i,

    input  tanimlamalar_pkg::sonuc_t ibr_sonuc_i,
    input  tanimlamalar_pkg::sonuc_t crp_sonuc_i,
    input  logic [4:0]               rd_adres_i,

    output tanimlamalar_pkg::yazma_t gy_yaz_o
);

    tanimlamalar_pkg::sonuc_t secilen;

    logic        gecerli_r;
    logic [4:0]  adres_r;
    logic [31:0] deger_r;

    // at most one unit flags its result, so a plain priority pick is enough.
    assign secilen = ibr_sonuc_i.gecerli ? ibr_sonuc_i : crp_sonuc_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gecerli_r <= 1'b0;
        end else begin
            gecerli_r <= secilen.gecerli && (rd_adres_i != 5'd0);
        end
    end

    always_ff @(posedge clk_i) begin
        adres_r <= rd_adres_i;
        deger_r <= secilen.deger;
    end

    assign gy_yaz_o.gecerli = gecerli_r;
    assign gy_yaz_o.adres   = adres_r;
    assign gy_yaz_o.deger   = deger_r;

endmodule

`default_nettype wire

//--- getir.sv
// fetch stage: word PC, instruction memory port and the fetch/decode register.
`default_nettype none

module getir #(
    parameter logic [31:0] BASLANGIC_PS = 32'h0000_0000
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    input  logic                      l1b_bekle_i,
    input  logic [31:0]               l1b_deger_i,
    output logic                      l1b_chip_select_n_o,
    output logic [29:0]               l1b_adr_o,

    output tanimlamalar_pkg::buyruk_t cyo_buyruk_o
);

    logic [29:0] ps_r;
    logic        cs_n_r;
    logic        kabul;

    logic        gecerli_r;
    logic [31:0] buyruk_r;
    logic [29:0] buyruk_ps_r;

    // a word is taken only while selected and the memory is not waiting.
    assign kabul = !cs_n_r && !l1b_bekle_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cs_n_r    <= 1'b1;
            ps_r      <= BASLANGIC_PS[31:2];
            gecerli_r <= 1'b0;
        end else begin
            cs_n_r    <= 1'b0;
            gecerli_r <= kabul;
            if (kabul) begin
                ps_r <= ps_r + 30'd1;
            end
        end
    end

    // payload follows the port every cycle, gecerli marks the bubbles.
    always_ff @(posedge clk_i) begin
        buyruk_r    <= l1b_deger_i;
        buyruk_ps_r <= ps_r;
    end

    assign l1b_chip_select_n_o = cs_n_r;
    assign l1b_adr_o           = ps_r;

    assign cyo_buyruk_o.gecerli = gecerli_r;
    assign cyo_buyruk_o.buyruk  = buyruk_r;
    assign cyo_buyruk_o.ps      = buyruk_ps_r;

endmodule

`default_nettype wire

//--- tanimlamalar_pkg.sv
// core package: micro-op enum, pipeline stage structs and opcode field constants.
`default_nettype none

package tanimlamalar_pkg;

    // operations carried from decode to the execute units.
    typedef enum logic [3:0] {
        ISLEM_NOP,
        ISLEM_ADD,
        ISLEM_SUB,
        ISLEM_AND,
        ISLEM_OR,
        ISLEM_XOR,
        ISLEM_SLT,
        ISLEM_SLTU,
        ISLEM_SLL,
        ISLEM_SRL,
        ISLEM_SRA,
        ISLEM_LUI,
        ISLEM_MUL,
        ISLEM_MULH,
        ISLEM_MULHU
    } mikroislem_e;

    // fetch to decode, ps is the word address.
    typedef struct packed {
        logic        gecerli;
        logic [31:0] buyruk;
        logic [29:0] ps;
    } buyruk_t;

    // decode to execute, deger2 already holds the immediate when there is one.
    typedef struct packed {
        logic        gecerli;
        mikroislem_e mikroislem;
        logic [4:0]  rd_adres;
        logic [31:0] deger1;
        logic [31:0] deger2;
    } islem_t;

    typedef struct packed {
        logic        gecerli;
        logic [4:0]  adres;
        logic [31:0] deger;
    } yazma_t;

    typedef struct packed {
        logic        gecerli;
        logic [31:0] deger;
    } sonuc_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

endpackage

`default_nettype wire

//--- vlog.f
tanimlamalar_pkg.sv
getir.sv
coz_yazmacoku.sv
aritmetik_mantik_birimi.sv
carpma_birimi.sv
geri_yaz.sv
cekirdek.sv
cekirdek_denetleyici.sv
cekirdek_tb.sv
